// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exec_core
FLIST     ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== alu.sv ====
`timescale 1ns/1ps

module alu #(
    parameter int XLEN = rv_pkg::XLEN
) (
    ctrl_if.consumer          ctrl,
    input  rv_pkg::alu_ctrl_e alu_ctrl_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   rs1_i,
    input  logic [XLEN-1:0]   rs2_i,
    input  logic [XLEN-1:0]   imm_i,
    input  logic [XLEN-1:0]   mem_rdata_i,
    output logic [XLEN-1:0]   alu_result_o,  // Also the memory address
    output logic [XLEN-1:0]   result_o
);

    localparam int shamt_w = $clog2(XLEN);

    logic [XLEN-1:0]    op_a;
    logic [XLEN-1:0]    op_b;
    logic [shamt_w-1:0] shamt;

    assign op_a  = ctrl.alu_src_a_pc ? pc_i : rs1_i;
    assign op_b  = ctrl.alu_src ? imm_i : rs2_i;
    assign shamt = op_b[shamt_w-1:0];

    always_comb begin
        case (alu_ctrl_i)
            rv_pkg::ADD:    alu_result_o = op_a + op_b;
            rv_pkg::SUB:    alu_result_o = op_a - op_b;
            rv_pkg::AND:    alu_result_o = op_a & op_b;
            rv_pkg::OR:     alu_result_o = op_a | op_b;
            rv_pkg::XOR:    alu_result_o = op_a ^ op_b;
            rv_pkg::SLL:    alu_result_o = op_a << shamt;
            rv_pkg::SRL:    alu_result_o = op_a >> shamt;
            rv_pkg::SRA:    alu_result_o = $signed(op_a) >>> shamt;
            rv_pkg::SLT:    alu_result_o = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::SLTU:   alu_result_o = {{(XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::PASS_B: alu_result_o = op_b;  // LUI
            default:        alu_result_o = '0;
        endcase
    end

    // Write-back select
    always_comb begin
        case (ctrl.result_src)
            rv_pkg::RES_MEM: result_o = mem_rdata_i;
            rv_pkg::RES_PC4: result_o = pc_i + XLEN'(4);
            default:         result_o = alu_result_o;
        endcase
    end

endmodule

// ==== alu_decoder.sv ====
`timescale 1ns/1ps

module alu_decoder (
    ctrl_if.consumer          ctrl,
    input  logic [2:0]        funct3_i,
    input  logic              funct7_b5_i,
    input  logic              is_op_imm_i,  // Immediate form, no SUB
    output rv_pkg::alu_ctrl_e alu_ctrl_o
);

    always_comb begin
        case (ctrl.alu_op)
            rv_pkg::ALUOP_ADD:    alu_ctrl_o = rv_pkg::ADD;
            rv_pkg::ALUOP_SUB:    alu_ctrl_o = rv_pkg::SUB;
            rv_pkg::ALUOP_PASS_B: alu_ctrl_o = rv_pkg::PASS_B;
            default: begin
                // Register and immediate arithmetic
                case (funct3_i)
                    3'b000: begin
                        if (funct7_b5_i && !is_op_imm_i) alu_ctrl_o = rv_pkg::SUB;
                        else alu_ctrl_o = rv_pkg::ADD;
                    end
                    3'b001:  alu_ctrl_o = rv_pkg::SLL;
                    3'b010:  alu_ctrl_o = rv_pkg::SLT;
                    3'b011:  alu_ctrl_o = rv_pkg::SLTU;
                    3'b100:  alu_ctrl_o = rv_pkg::XOR;
                    3'b101: begin
                        // Bit 5 picks arithmetic shift, SRAI included
                        if (funct7_b5_i) alu_ctrl_o = rv_pkg::SRA;
                        else alu_ctrl_o = rv_pkg::SRL;
                    end
                    3'b110:  alu_ctrl_o = rv_pkg::OR;
                    default: alu_ctrl_o = rv_pkg::AND;
                endcase
            end
        endcase
    end

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit #(
    parameter int XLEN = rv_pkg::XLEN
) (
    ctrl_if.consumer        ctrl,
    input  logic [2:0]      funct3_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] imm_i,
    output logic            taken_o,
    output logic [XLEN-1:0] next_pc_o
);

    logic            cond;    // Branch condition met
    logic [XLEN-1:0] target;

    always_comb begin
        case (funct3_i)
            3'b000:  cond = (rs1_i == rs2_i);                  // BEQ
            3'b001:  cond = (rs1_i != rs2_i);                  // BNE
            3'b100:  cond = ($signed(rs1_i) < $signed(rs2_i));  // BLT
            3'b101:  cond = ($signed(rs1_i) >= $signed(rs2_i)); // BGE
            3'b110:  cond = (rs1_i < rs2_i);                   // BLTU
            3'b111:  cond = (rs1_i >= rs2_i);                  // BGEU
            default: cond = 1'b0;
        endcase
    end

    assign taken_o = ctrl.jump | (ctrl.branch & cond);

    // JALR clears bit 0 of the sum
    assign target    = ctrl.jump_reg ? ((rs1_i + imm_i) & ~XLEN'(1)) : (pc_i + imm_i);
    assign next_pc_o = taken_o ? target : (pc_i + XLEN'(4));

endmodule

// ==== compile.f ====
rv_pkg.sv
ctrl_if.sv
main_decoder.sv
alu_decoder.sv
imm_extend.sv
reg_file.sv
alu.sv
branch_unit.sv
exec_core.sv
exec_core_sva.sv
tb_exec_core.sv

// ==== ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrl_if ();
    logic                reg_wr_en;
    logic                mem_wr_en;
    rv_pkg::imm_src_e    imm_src;
    logic                alu_src;       // B operand is the immediate
    logic                alu_src_a_pc;  // A operand is the PC
    logic                branch;        // Conditional branch
    logic                jump;
    logic                jump_reg;      // JALR, target from rs1
    rv_pkg::result_src_e result_src;
    rv_pkg::alu_op_e     alu_op;
    logic [3:0]          byte_en;

    // Decoder side
    modport producer (output reg_wr_en, mem_wr_en, imm_src, alu_src, alu_src_a_pc,
                      branch, jump, jump_reg, result_src, alu_op, byte_en);

    modport consumer (input reg_wr_en, mem_wr_en, imm_src, alu_src, alu_src_a_pc,
                      branch, jump, jump_reg, result_src, alu_op, byte_en);
endinterface

// ==== exec_core.sv ====
`timescale 1ns/1ps

module exec_core #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic [XLEN-1:0] instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] mem_rdata_i,  // Full word from data memory
    output logic [XLEN-1:0] result_o,
    output logic [XLEN-1:0] mem_addr_o,
    output logic [XLEN-1:0] mem_wdata_o,
    output logic            mem_wr_en_o,
    output logic [3:0]      byte_en_o,
    output logic            branch_taken_o,
    output logic [XLEN-1:0] next_pc_o
);

    ctrl_if ctrl ();

    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    rv_pkg::alu_ctrl_e alu_ctrl;

    main_decoder i_main_decoder (.opcode_i(rv_pkg::opcode_e'(instr_i[6:0])),
        .funct3_i(instr_i[14:12]), .ctrl(ctrl.producer));

    // Opcode bit 5 is clear for OP_IMM
    alu_decoder i_alu_decoder (.ctrl(ctrl.consumer), .funct3_i(instr_i[14:12]),
        .funct7_b5_i(instr_i[30]), .is_op_imm_i(~instr_i[5]), .alu_ctrl_o(alu_ctrl));

    imm_extend #(.XLEN(XLEN)) i_imm_extend (.instr_i(instr_i), .ctrl(ctrl.consumer),
        .imm_o(imm));

    reg_file #(.XLEN(XLEN)) i_reg_file (.clk_i(clk_i), .rst_n_i(rst_n_i),
        .rs1_addr_i(instr_i[19:15]), .rs2_addr_i(instr_i[24:20]), .rd_addr_i(instr_i[11:7]),
        .wr_en_i(ctrl.reg_wr_en), .wr_data_i(result_o),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data));

    alu #(.XLEN(XLEN)) i_alu (.ctrl(ctrl.consumer), .alu_ctrl_i(alu_ctrl), .pc_i(pc_i),
        .rs1_i(rs1_data), .rs2_i(rs2_data), .imm_i(imm), .mem_rdata_i(mem_rdata_i),
        .alu_result_o(mem_addr_o), .result_o(result_o));

    branch_unit #(.XLEN(XLEN)) i_branch_unit (.ctrl(ctrl.consumer),
        .funct3_i(instr_i[14:12]), .pc_i(pc_i), .rs1_i(rs1_data), .rs2_i(rs2_data),
        .imm_i(imm), .taken_o(branch_taken_o), .next_pc_o(next_pc_o));

    assign mem_wdata_o = rs2_data;
    assign byte_en_o   = ctrl.byte_en;
    assign mem_wr_en_o = ctrl.mem_wr_en & rst_n_i;  // No stores during reset

endmodule

// ==== exec_core_sva.sv ====
`timescale 1ns/1ps

module exec_core_sva (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic [6:0]  opcode_i,
    input logic        reg_wr_en_i,
    input logic        mem_wr_en_i,
    input logic        jump_reg_i,
    input logic [3:0]  byte_en_i,
    input logic [31:0] next_pc_i,
    input logic [31:0] rs1_data_i
);

    logic is_mem;  // Load or store decoded

    assign is_mem = (opcode_i == rv_pkg::LOAD) || (opcode_i == rv_pkg::STORE);

    a_one_writer: assert property (@(posedge clk_i) !(reg_wr_en_i && mem_wr_en_i))
        else $error("register and memory write active together");

    a_be_idle: assert property (@(posedge clk_i) !is_mem |-> (byte_en_i == 4'b0000))
        else $error("byte enables set without a load or store");

    // Only JALR may produce a target with bit 1 set
    a_pc_align: assert property (@(posedge clk_i)
        (next_pc_i[0] == 1'b0) && (jump_reg_i || (next_pc_i[1] == 1'b0)))
        else $error("next PC misaligned");

    // Register read after a reset edge still shows the cleared value
    a_rst_quiet: assert property (@(posedge clk_i) !rst_n_i |=> (rs1_data_i == 32'd0))
        else $error("register written during reset");

endmodule

bind exec_core exec_core_sva i_exec_core_sva (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .opcode_i(instr_i[6:0]),
    .reg_wr_en_i(ctrl.reg_wr_en), .mem_wr_en_i(mem_wr_en_o), .jump_reg_i(ctrl.jump_reg),
    .byte_en_i(byte_en_o), .next_pc_i(next_pc_o), .rs1_data_i(rs1_data)
);

// ==== imm_extend.sv ====
`timescale 1ns/1ps

module imm_extend #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic [XLEN-1:0] instr_i,
    ctrl_if.consumer        ctrl,
    output logic [XLEN-1:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (ctrl.imm_src)
            rv_pkg::IMM_I:     imm_o = {{(XLEN-12){sign}}, instr_i[31:20]};
            rv_pkg::IMM_SHAMT: imm_o = {{(XLEN-5){1'b0}}, instr_i[24:20]};  // Zero extended
            rv_pkg::IMM_S:     imm_o = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            rv_pkg::IMM_B: begin
                imm_o = {{(XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            rv_pkg::IMM_J: begin
                // Offset bits 20, 10:1, 11, 19:12 scattered in the word
                imm_o = {{(XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            rv_pkg::IMM_U:     imm_o = {instr_i[31:12], 12'h000};
            default:           imm_o = '0;
        endcase
    end

endmodule

// ==== main_decoder.sv ====
`timescale 1ns/1ps

module main_decoder (
    input  rv_pkg::opcode_e opcode_i,  // Opcode from instruction
    input  logic [2:0]      funct3_i,
    ctrl_if.producer        ctrl
);

    logic [3:0] size_be;  // Access width from funct3[1:0]

    always_comb begin
        case (funct3_i[1:0])
            2'b00:   size_be = 4'b0001;  // Byte
            2'b01:   size_be = 4'b0011;  // Half
            2'b10:   size_be = 4'b1111;  // Word
            default: size_be = 4'b0000;
        endcase
    end

    always_comb begin
        // All inactive unless the opcode says otherwise
        ctrl.reg_wr_en    = 1'b0;
        ctrl.mem_wr_en    = 1'b0;
        ctrl.imm_src      = rv_pkg::IMM_NONE;
        ctrl.alu_src      = 1'b0;
        ctrl.alu_src_a_pc = 1'b0;
        ctrl.branch       = 1'b0;
        ctrl.jump         = 1'b0;
        ctrl.jump_reg     = 1'b0;
        ctrl.result_src   = rv_pkg::RES_ALU;
        ctrl.alu_op       = rv_pkg::ALUOP_ADD;
        ctrl.byte_en      = 4'b0000;

        case (opcode_i)
            rv_pkg::LOAD: begin
                ctrl.reg_wr_en  = 1'b1;
                ctrl.imm_src    = rv_pkg::IMM_I;
                ctrl.alu_src    = 1'b1;
                ctrl.result_src = rv_pkg::RES_MEM;
                // funct3 11x and 011 are not loads
                ctrl.byte_en    = (funct3_i[2] & funct3_i[1]) ? 4'b0000 : size_be;
            end
            rv_pkg::OP_IMM: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = rv_pkg::ALUOP_FUNCT;
                // SLLI, SRLI and SRAI take a shift amount
                if (funct3_i[1:0] == 2'b01) begin
                    ctrl.imm_src = rv_pkg::IMM_SHAMT;
                end else begin
                    ctrl.imm_src = rv_pkg::IMM_I;
                end
            end
            rv_pkg::STORE: begin
                ctrl.mem_wr_en = 1'b1;
                ctrl.imm_src   = rv_pkg::IMM_S;
                ctrl.alu_src   = 1'b1;
                ctrl.byte_en   = funct3_i[2] ? 4'b0000 : size_be;
            end
            rv_pkg::OP: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.alu_op    = rv_pkg::ALUOP_FUNCT;
            end
            rv_pkg::BRANCH: begin
                ctrl.imm_src = rv_pkg::IMM_B;
                ctrl.branch  = 1'b1;
                ctrl.alu_op  = rv_pkg::ALUOP_SUB;
            end
            rv_pkg::JAL: begin
                ctrl.reg_wr_en  = 1'b1;
                ctrl.imm_src    = rv_pkg::IMM_J;
                ctrl.jump       = 1'b1;
                ctrl.result_src = rv_pkg::RES_PC4;  // Link address
            end
            rv_pkg::JALR: begin
                ctrl.reg_wr_en  = 1'b1;
                ctrl.imm_src    = rv_pkg::IMM_I;
                ctrl.alu_src    = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.jump_reg   = 1'b1;
                ctrl.result_src = rv_pkg::RES_PC4;
            end
            rv_pkg::LUI: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.imm_src   = rv_pkg::IMM_U;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = rv_pkg::ALUOP_PASS_B;
            end
            rv_pkg::AUIPC: begin
                ctrl.reg_wr_en    = 1'b1;
                ctrl.imm_src      = rv_pkg::IMM_U;
                ctrl.alu_src      = 1'b1;
                ctrl.alu_src_a_pc = 1'b1;  // PC + U immediate
            end
            default: ;
        endcase
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file #(
    parameter int XLEN = rv_pkg::XLEN
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    input  logic [4:0]      rd_addr_i,
    input  logic            wr_en_i,
    input  logic [XLEN-1:0] wr_data_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (rd_addr_i != 5'd0)) begin  // x0 stays zero
            regs[rd_addr_i] <= wr_data_i;
        end
    end

    // Asynchronous reads
    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 32;  // Data path width

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_J, IMM_U, IMM_NONE
    } imm_src_e;

    typedef enum logic [1:0] {
        ALUOP_ADD, ALUOP_SUB, ALUOP_FUNCT, ALUOP_PASS_B
    } alu_op_e;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASS_B
    } alu_ctrl_e;

    // Write-back source
    typedef enum logic [1:0] {
        RES_ALU, RES_MEM, RES_PC4
    } result_src_e;

endpackage

// ==== tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core;

    localparam logic [6:0] OPC_LOAD   = 7'h03;
    localparam logic [6:0] OPC_OP_IMM = 7'h13;
    localparam logic [6:0] OPC_AUIPC  = 7'h17;
    localparam logic [6:0] OPC_STORE  = 7'h23;
    localparam logic [6:0] OPC_OP     = 7'h33;
    localparam logic [6:0] OPC_LUI    = 7'h37;
    localparam logic [6:0] OPC_BRANCH = 7'h63;
    localparam logic [6:0] OPC_JALR   = 7'h67;
    localparam logic [6:0] OPC_JAL    = 7'h6f;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rdata;
        logic [31:0] res;
        logic        chk_res;  // Result is meaningful
        logic        wr;
        logic [3:0]  be;
        logic        taken;
        logic [31:0] npc;
        logic [31:0] addr;
        logic [31:0] wdata;
    } vec_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] mem_rdata;
    logic [31:0] result;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_wr_en;
    logic [3:0]  byte_en;
    logic        branch_taken;
    logic [31:0] next_pc;

    vec_t        tbl [64];
    int          n_vec;
    int          idx;
    int          errors;
    int          checks;
    integer      seed;
    logic [31:0] cur_pc;  // PC and load data for the entry being built
    logic [31:0] cur_rd;

    exec_core #(.XLEN(32)) i_exec_core (
        .clk_i(clk), .rst_n_i(rst_n), .instr_i(instr), .pc_i(pc), .mem_rdata_i(mem_rdata),
        .result_o(result), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
        .mem_wr_en_o(mem_wr_en), .byte_en_o(byte_en), .branch_taken_o(branch_taken),
        .next_pc_o(next_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_vec(input logic [31:0] instr_v, input logic [31:0] res_v,
                           input logic chk_v, input logic [3:0] be_v, input logic taken_v,
                           input logic [31:0] npc_v, input logic wr_v,
                           input logic [31:0] addr_v, input logic [31:0] wdata_v);
        tbl[n_vec] = {instr_v, cur_pc, cur_rd, res_v, chk_v, wr_v, be_v, taken_v, npc_v,
                      addr_v, wdata_v};
        n_vec++;
        cur_pc = $random(seed) & 32'hFFFF_FFFC;  // Word aligned
        cur_rd = $random(seed);
    endtask

    // Plain write-back instruction, falls through to PC + 4
    task automatic add_alu(input logic [31:0] instr_v, input logic [31:0] res_v);
        add_vec(instr_v, res_v, 1'b1, 4'b0000, 1'b0, cur_pc + 32'd4, 1'b0, 32'd0, 32'd0);
    endtask

    task automatic add_store(input logic [31:0] instr_v, input logic [3:0] be_v,
                             input logic [31:0] addr_v, input logic [31:0] wdata_v);
        add_vec(instr_v, 32'd0, 1'b0, be_v, 1'b0, cur_pc + 32'd4, 1'b1, addr_v, wdata_v);
    endtask

    // Branch by -32 with the outcome from the RV32I compare rules
    task automatic add_branch(input logic [2:0] f3, input logic [4:0] rs1_a,
                              input logic [4:0] rs2_a, input logic [31:0] a,
                              input logic [31:0] b);
        logic        t;
        logic [31:0] npc;
        case (f3)
            3'b000:  t = (a == b);
            3'b001:  t = (a != b);
            3'b100:  t = ($signed(a) < $signed(b));
            3'b101:  t = ($signed(a) >= $signed(b));
            3'b110:  t = (a < b);
            default: t = (a >= b);
        endcase
        npc = t ? (cur_pc + 32'hFFFF_FFE0) : (cur_pc + 32'd4);
        add_vec(enc_b(13'h1FE0, rs2_a, rs1_a, f3), 32'd0, 1'b0, 4'b0000, t, npc, 1'b0,
                32'd0, 32'd0);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s at entry %0d: got %h, expected %h", name, idx, got, exp);
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            if (cycles == 20) begin
                $display("Timeout: reset was never released");
                $display("tests failed");
                $finish;
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    task automatic build_table();
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [31:0] ld;
        r1 = 32'h0000_0345;
        r2 = 32'hFFFF_FFF0;
        r3 = 32'd3;
        add_alu(enc_i(12'h345, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), r1);
        add_alu(enc_i(12'hFF0, 5'd0, 3'b000, 5'd2, OPC_OP_IMM), r2);
        add_alu(enc_i(12'h003, 5'd0, 3'b000, 5'd3, OPC_OP_IMM), r3);
        add_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd4), r1 + r2);
        add_alu(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd5), r1 - r2);
        add_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd6), r1 & r2);
        add_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd7), r1 | r2);
        add_alu(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), r1 ^ r2);
        add_alu(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd9), {31'd0, $signed(r2) < $signed(r1)});
        add_alu(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd10), {31'd0, r2 < r1});
        add_alu(enc_r(7'h00, 5'd3, 5'd1, 3'b001, 5'd11), r1 << r3[4:0]);
        add_alu(enc_r(7'h00, 5'd3, 5'd2, 3'b101, 5'd12), r2 >> r3[4:0]);
        add_alu(enc_r(7'h20, 5'd3, 5'd2, 3'b101, 5'd13), $unsigned($signed(r2) >>> r3[4:0]));
        add_alu(enc_i(12'h005, 5'd0, 3'b000, 5'd0, OPC_OP_IMM), 32'd5);  // Write to x0 dropped
        add_alu(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd15), r1);
        add_alu({20'hABCDE, 5'd16, OPC_LUI}, 32'hABCD_E000);
        add_alu({20'h12345, 5'd17, OPC_AUIPC}, cur_pc + 32'h1234_5000);
        add_store(enc_s(12'h008, 5'd2, 5'd1, 3'b000), 4'b0001, r1 + 32'd8, r2);
        add_store(enc_s(12'hFFC, 5'd2, 5'd1, 3'b001), 4'b0011, r1 - 32'd4, r2);
        add_store(enc_s(12'h000, 5'd1, 5'd2, 3'b010), 4'b1111, r2, r1);
        ld = cur_rd;
        add_vec(enc_i(12'h004, 5'd1, 3'b010, 5'd18, OPC_LOAD), ld, 1'b1, 4'b1111, 1'b0,
                cur_pc + 32'd4, 1'b0, 32'd0, 32'd0);
        add_alu(enc_r(7'h00, 5'd1, 5'd18, 3'b000, 5'd19), ld + r1);
        add_branch(3'b000, 5'd1, 5'd1, r1, r1);
        add_branch(3'b000, 5'd1, 5'd2, r1, r2);
        add_branch(3'b001, 5'd1, 5'd2, r1, r2);
        add_branch(3'b001, 5'd1, 5'd1, r1, r1);
        add_branch(3'b100, 5'd2, 5'd1, r2, r1);
        add_branch(3'b100, 5'd1, 5'd2, r1, r2);
        add_branch(3'b101, 5'd1, 5'd2, r1, r2);
        add_branch(3'b101, 5'd2, 5'd1, r2, r1);
        add_branch(3'b110, 5'd1, 5'd2, r1, r2);
        add_branch(3'b110, 5'd2, 5'd1, r2, r1);
        add_branch(3'b111, 5'd2, 5'd1, r2, r1);
        add_branch(3'b111, 5'd1, 5'd2, r1, r2);
        add_vec(enc_j(21'h000100, 5'd20), cur_pc + 32'd4, 1'b1, 4'b0000, 1'b1,
                cur_pc + 32'h100, 1'b0, 32'd0, 32'd0);
        // rs1 is odd here, so the cleared low bit matters
        add_vec(enc_i(12'h03C, 5'd1, 3'b000, 5'd21, OPC_JALR), cur_pc + 32'd4, 1'b1, 4'b0000,
                1'b1, (r1 + 32'h3C) & 32'hFFFF_FFFE, 1'b0, 32'd0, 32'd0);
    endtask

    initial begin
        rst_n     = 1'b0;
        instr     = enc_i(12'h005, 5'd1, 3'b000, 5'd1, OPC_OP_IMM);  // Write held off by reset
        pc        = 32'd0;
        mem_rdata = 32'd0;
        seed      = 58;
        n_vec     = 0;
        errors    = 0;
        checks    = 0;
        cur_pc    = $random(seed) & 32'hFFFF_FFFC;
        cur_rd    = $random(seed);
        build_table();

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        instr <= 32'd0;
        wait_reset_release();

        for (idx = 0; idx < n_vec; idx++) begin
            @(posedge clk);
            instr     <= tbl[idx].instr;
            pc        <= tbl[idx].pc;
            mem_rdata <= tbl[idx].rdata;
            @(negedge clk);  // Combinational outputs settled
            if (tbl[idx].chk_res) check_val("result_o", result, tbl[idx].res);
            check_val("mem_wr_en_o", {31'd0, mem_wr_en}, {31'd0, tbl[idx].wr});
            check_val("byte_en_o", {28'd0, byte_en}, {28'd0, tbl[idx].be});
            check_val("branch_taken_o", {31'd0, branch_taken}, {31'd0, tbl[idx].taken});
            check_val("next_pc_o", next_pc, tbl[idx].npc);
            if (tbl[idx].wr) begin
                check_val("mem_addr_o", mem_addr, tbl[idx].addr);
                check_val("mem_wdata_o", mem_wdata, tbl[idx].wdata);
            end
        end

        $display("Entries: %0d, checks: %0d, errors: %0d", n_vec, checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
